// File: decode_config.svh
/*
 * Decode and issue stage configuration
 * Register file geometry, datapath width and sequence-number width
 */

`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// Architectural register count
`define DEC_NUM_REGS 32

// Register index width, log2 of the register count
`define DEC_REG_ADDR_BITS 5

// Datapath width
`define DEC_XLEN 32

// Sequence number assigned by fetch
`define DEC_SEQ_BITS 8

`endif

// File: decode_pkg.sv
/*
 * Decode and issue package
 * Shared vector types, micro-op encoding and the packets exchanged
 * between fetch, decode, issue, the pipes and writeback
 */

`default_nettype none

`include "decode_config.svh"

package decode_pkg;

  typedef logic [`DEC_XLEN-1:0]          word_t;
  typedef logic [`DEC_REG_ADDR_BITS-1:0] reg_addr_t;
  typedef logic [`DEC_SEQ_BITS-1:0]      seq_t;

  // Immediate forms share the register-form micro-op
  typedef enum logic [2:0] {
    UOP_ADD,
    UOP_SUB,
    UOP_AND,
    UOP_OR,
    UOP_XOR,
    UOP_SLT,
    UOP_LUI,
    UOP_MUL
  } uop_t;

  // --------------------
  // Packets
  // --------------------

  typedef struct packed {
    word_t inst;
    word_t pc;
    seq_t  seq;
  } fetch_pkt_t;

  typedef struct packed {
    logic      legal;
    uop_t      uop;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    logic      rd_wen;
    logic      use_rs2;
    logic      use_imm;
    word_t     imm;
  } decode_t;

  typedef struct packed {
    word_t     pc;
    seq_t      seq;
    uop_t      uop;
    reg_addr_t rd;
    logic      rd_wen;
    word_t     op1;
    word_t     op2;
  } issue_pkt_t;

  typedef struct packed {
    logic      val;
    reg_addr_t rd;
    logic      rd_wen;
    word_t     wdata;
  } complete_t;

  // One-cycle event strobes for the CSR counters
  typedef struct packed {
    logic issued;
    logic stalled;
    logic illegal;
  } issue_events_t;

endpackage

`default_nettype wire

// File: inst_decoder.sv
/*
 * Instruction decoder
 * Combinational RV32 subset decode into micro-op, register
 * indices, write enable and immediate
 */

`timescale 1ns/100ps
`default_nettype none

module inst_decoder (
  input  decode_pkg::word_t   inst,
  output decode_pkg::decode_t dec
);

  import decode_pkg::*;

  // Major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [9:0] funct;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  // funct7 and funct3 together pick the R-type op
  assign funct  = {funct7, funct3};

  always_comb begin
    // Defaults describe an illegal word
    dec         = '0;
    dec.uop     = UOP_ADD;
    dec.rs1     = inst[19:15];
    dec.rs2     = inst[24:20];
    dec.rd      = inst[11:7];

    case (opcode)
      OPC_OP: begin
        dec.legal   = 1'b1;
        dec.use_rs2 = 1'b1;
        case (funct)
          10'b0000000_000: dec.uop = UOP_ADD;
          10'b0100000_000: dec.uop = UOP_SUB;
          10'b0000000_111: dec.uop = UOP_AND;
          10'b0000000_110: dec.uop = UOP_OR;
          10'b0000000_100: dec.uop = UOP_XOR;
          10'b0000000_010: dec.uop = UOP_SLT;
          10'b0000001_000: dec.uop = UOP_MUL;
          default:         dec.legal = 1'b0;
        endcase
      end
      OPC_OP_IMM: begin
        dec.legal   = 1'b1;
        dec.use_imm = 1'b1;
        dec.rs2     = '0;
        // I-type immediate, sign extended
        dec.imm     = {{20{inst[31]}}, inst[31:20]};
        case (funct3)
          3'b000:  dec.uop = UOP_ADD;
          3'b111:  dec.uop = UOP_AND;
          3'b110:  dec.uop = UOP_OR;
          3'b100:  dec.uop = UOP_XOR;
          default: dec.legal = 1'b0;
        endcase
      end
      OPC_LUI: begin
        dec.legal   = 1'b1;
        dec.use_imm = 1'b1;
        dec.uop     = UOP_LUI;
        // No source read, so x0 keeps it hazard free
        dec.rs1     = '0;
        dec.rs2     = '0;
        dec.imm     = {inst[31:12], 12'b0};
      end
      default: dec.legal = 1'b0;
    endcase

    // Only legal words write a register
    dec.rd_wen = dec.legal;
  end

  // Operand select must be one or the other
  always_comb begin
    assert (!(dec.legal && dec.use_imm && dec.use_rs2))
      else $error("decoder selected both immediate and rs2");
  end

endmodule

`default_nettype wire

// File: regfile_pending.sv
/*
 * Register file with pending bits
 * Two combinational read ports, one completion write port and
 * a scoreboard bit per register for RAW and WAW stalls
 */

`timescale 1ns/100ps
`default_nettype none

`include "decode_config.svh"

module regfile_pending (
  input  logic                  clk,
  input  logic                  rst,
  input  decode_pkg::reg_addr_t raddr0,
  input  decode_pkg::reg_addr_t raddr1,
  output decode_pkg::word_t     rdata0,
  output decode_pkg::word_t     rdata1,
  output logic                  rpend0,
  output logic                  rpend1,
  input  decode_pkg::reg_addr_t check_addr,
  output logic                  check_pend,
  input  logic                  pending_set_val,
  input  decode_pkg::reg_addr_t pending_set_addr,
  input  decode_pkg::complete_t complete
);

  import decode_pkg::*;

  word_t                    regs [`DEC_NUM_REGS];
  logic [`DEC_NUM_REGS-1:0] pending;
  logic                     wr_en;

  // x0 is never written
  assign wr_en = complete.val && complete.rd_wen && (complete.rd != '0);

  // --------------------
  // Reads
  // --------------------

  // x0 reads zero and is never pending
  assign rdata0     = (raddr0 == '0) ? '0 : regs[raddr0];
  assign rdata1     = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rpend0     = (raddr0 != '0) && pending[raddr0];
  assign rpend1     = (raddr1 != '0) && pending[raddr1];
  assign check_pend = (check_addr != '0) && pending[check_addr];

  // --------------------
  // Writes
  // --------------------

  always_ff @(posedge clk) begin
    if (wr_en) begin
      regs[complete.rd] <= complete.wdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= '0;
    end else begin
      if (wr_en) begin
        pending[complete.rd] <= 1'b0;
      end
      // Set wins over clear on the same register
      if (pending_set_val && (pending_set_addr != '0)) begin
        pending[pending_set_addr] <= 1'b1;
      end
    end
  end

  // Writeback only for an outstanding issue
  assert property (@(posedge clk) disable iff (rst)
    wr_en |-> pending[complete.rd])
    else $error("completion to register x%0d that is not pending", complete.rd);

  // Issue never reaches a busy destination, WAW stall upstream
  assert property (@(posedge clk) disable iff (rst)
    (pending_set_val && (pending_set_addr != '0)) |-> !pending[pending_set_addr])
    else $error("pending set on busy register x%0d", pending_set_addr);

endmodule

`default_nettype wire

// File: issue_unit.sv
/*
 * Issue unit
 * One-entry issue register, scoreboard stall, routing to the
 * ALU and multiplier pipes, and the fetch ready logic
 */

`timescale 1ns/100ps
`default_nettype none

module issue_unit (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      fetch_val,
  output logic                      fetch_rdy,
  input  decode_pkg::fetch_pkt_t    fetch_pkt,
  input  decode_pkg::decode_t       dec,
  output decode_pkg::word_t         inst,
  output decode_pkg::reg_addr_t     raddr0,
  output decode_pkg::reg_addr_t     raddr1,
  input  decode_pkg::word_t         rdata0,
  input  decode_pkg::word_t         rdata1,
  input  logic                      rpend0,
  input  logic                      rpend1,
  input  logic                      check_pend,
  output logic                      pending_set_val,
  output decode_pkg::reg_addr_t     pending_set_addr,
  output logic [1:0]                pipe_val,
  input  logic [1:0]                pipe_rdy,
  output decode_pkg::issue_pkt_t    pipe_pkt,
  input  logic                      issue_en,
  output decode_pkg::issue_events_t events
);

  import decode_pkg::*;

  logic       entry_val;
  fetch_pkt_t entry;
  logic       fetch_xfer;
  logic       issue_xfer;
  logic       drop;
  logic       hazard;
  logic       can_issue;
  logic       to_mul;

  // --------------------
  // Issue register
  // --------------------

  assign fetch_xfer = fetch_val && fetch_rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      entry_val <= 1'b0;
    end else if (fetch_xfer) begin
      entry_val <= 1'b1;
    end else if (issue_xfer || drop) begin
      entry_val <= 1'b0;
    end
  end

  // Instruction, pc and seq from fetch
  always_ff @(posedge clk) begin
    if (fetch_xfer) begin
      entry <= fetch_pkt;
    end
  end

  assign inst   = entry.inst;
  assign raddr0 = dec.rs1;
  assign raddr1 = dec.rs2;

  // --------------------
  // Hazards and routing
  // --------------------

  // Only the flags of registers actually used
  assign hazard = rpend0 || (dec.use_rs2 && rpend1) || (dec.rd_wen && check_pend);

  assign can_issue = entry_val && dec.legal && issue_en && !hazard;
  // mul to pipe 1, rest to the ALU
  assign to_mul    = (dec.uop == UOP_MUL);

  assign pipe_val[0] = can_issue && !to_mul;
  assign pipe_val[1] = can_issue && to_mul;

  assign issue_xfer = |(pipe_val & pipe_rdy);
  // Illegal words leave without a pipe
  assign drop       = entry_val && !dec.legal;

  // Space now, or space after this cycle
  assign fetch_rdy = !entry_val || issue_xfer || drop;

  // Scoreboard the destination on issue
  assign pending_set_val  = issue_xfer && dec.rd_wen && (dec.rd != '0);
  assign pending_set_addr = dec.rd;

  // Packet shared by both pipes
  always_comb begin
    pipe_pkt.pc     = entry.pc;
    pipe_pkt.seq    = entry.seq;
    pipe_pkt.uop    = dec.uop;
    pipe_pkt.rd     = dec.rd;
    pipe_pkt.rd_wen = dec.rd_wen;
    pipe_pkt.op1    = rdata0;
    pipe_pkt.op2    = dec.use_imm ? dec.imm : rdata1;
  end

  // --------------------
  // Events
  // --------------------

  assign events.issued  = issue_xfer;
  // Held by the scoreboard alone
  assign events.stalled = entry_val && dec.legal && issue_en && hazard;
  assign events.illegal = drop;

  assert property (@(posedge clk) disable iff (rst) $onehot0(pipe_val))
    else $error("both pipes offered the same instruction");

endmodule

`default_nettype wire

// File: issue_csr.sv
/*
 * Issue control and status
 * Wishbone classic slave with the issue enable bit and
 * saturating issued, stall and illegal counters
 */

`timescale 1ns/100ps
`default_nettype none

module issue_csr (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      wb_cyc,
  input  logic                      wb_stb,
  input  logic                      wb_we,
  input  logic [1:0]                wb_adr,
  input  decode_pkg::word_t         wb_dat_w,
  output decode_pkg::word_t         wb_dat_r,
  output logic                      wb_ack,
  input  decode_pkg::issue_events_t events,
  output logic                      issue_en
);

  import decode_pkg::*;

  word_t      cnt [3];
  logic [2:0] ev;
  logic       req;

  // Counter order matches word index 1 to 3
  assign ev  = {events.illegal, events.stalled, events.issued};
  // New request, not the cycle already acked
  assign req = wb_cyc && wb_stb && !wb_ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack   <= 1'b0;
      issue_en <= 1'b0;
      for (int i = 0; i < 3; i++) begin
        cnt[i] <= '0;
      end
    end else begin
      wb_ack <= req;
      if (req && wb_we && (wb_adr == 2'd0)) begin
        issue_en <= wb_dat_w[0];
      end
      for (int i = 0; i < 3; i++) begin
        // Host clear beats a same-cycle event
        if (req && wb_we && (wb_adr == 2'(i + 1))) begin
          cnt[i] <= '0;
        end else if (ev[i] && (cnt[i] != '1)) begin
          cnt[i] <= cnt[i] + 1'b1;
        end
      end
    end
  end

  // Read data lands with ack
  always_ff @(posedge clk) begin
    if (req) begin
      wb_dat_r <= (wb_adr == 2'd0) ? word_t'(issue_en) : cnt[wb_adr - 2'd1];
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    $rose(wb_ack) |-> $past(wb_cyc && wb_stb))
    else $error("ack without a bus cycle");

endmodule

`default_nettype wire

// File: decode_issue_top.sv
/*
 * Decode and issue stage top
 * Joins decoder, register file, issue unit and CSR block
 */

`timescale 1ns/100ps
`default_nettype none

module decode_issue_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   fetch_val,
  output logic                   fetch_rdy,
  input  decode_pkg::fetch_pkt_t fetch_pkt,
  output logic [1:0]             pipe_val,
  input  logic [1:0]             pipe_rdy,
  output decode_pkg::issue_pkt_t pipe_pkt,
  input  decode_pkg::complete_t  complete,
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  logic [1:0]             wb_adr,
  input  decode_pkg::word_t      wb_dat_w,
  output decode_pkg::word_t      wb_dat_r,
  output logic                   wb_ack
);

  import decode_pkg::*;

  decode_t       dec;
  word_t         inst;
  reg_addr_t     raddr0;
  reg_addr_t     raddr1;
  word_t         rdata0;
  word_t         rdata1;
  logic          rpend0;
  logic          rpend1;
  logic          check_pend;
  logic          pending_set_val;
  reg_addr_t     pending_set_addr;
  logic          issue_en;
  issue_events_t events;

  inst_decoder inst_decoder_i (
    .inst (inst),
    .dec  (dec)
  );

  // WAW check on the decoded destination
  regfile_pending regfile_pending_i (
    .clk              (clk),
    .rst              (rst),
    .raddr0           (raddr0),
    .raddr1           (raddr1),
    .rdata0           (rdata0),
    .rdata1           (rdata1),
    .rpend0           (rpend0),
    .rpend1           (rpend1),
    .check_addr       (dec.rd),
    .check_pend       (check_pend),
    .pending_set_val  (pending_set_val),
    .pending_set_addr (pending_set_addr),
    .complete         (complete)
  );

  issue_unit issue_unit_i (
    .clk              (clk),
    .rst              (rst),
    .fetch_val        (fetch_val),
    .fetch_rdy        (fetch_rdy),
    .fetch_pkt        (fetch_pkt),
    .dec              (dec),
    .inst             (inst),
    .raddr0           (raddr0),
    .raddr1           (raddr1),
    .rdata0           (rdata0),
    .rdata1           (rdata1),
    .rpend0           (rpend0),
    .rpend1           (rpend1),
    .check_pend       (check_pend),
    .pending_set_val  (pending_set_val),
    .pending_set_addr (pending_set_addr),
    .pipe_val         (pipe_val),
    .pipe_rdy         (pipe_rdy),
    .pipe_pkt         (pipe_pkt),
    .issue_en         (issue_en),
    .events           (events)
  );

  issue_csr issue_csr_i (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .events   (events),
    .issue_en (issue_en)
  );

endmodule

`default_nettype wire

// File: tb_decode_issue.sv
/*
 * Decode and issue stage testbench
 * Random fetch, pipe and writeback traffic from a fixed seed,
 * checked cycle by cycle against a reference model
 */

`timescale 1ns/100ps
`default_nettype none

module tb_decode_issue;

  import decode_pkg::*;

  localparam int WB_TIMEOUT     = 16;
  localparam int RESUME_TIMEOUT = 400;
  localparam int DRAIN_TIMEOUT  = 4000;

  // Reference decode result
  typedef struct packed {
    logic      legal;
    uop_t      uop;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    logic      use_rs1;
    logic      use_rs2;
    logic      use_imm;
    word_t     imm;
  } ref_dec_t;

  logic       clk;
  logic       rst;
  logic       fetch_val;
  logic       fetch_rdy;
  fetch_pkt_t fetch_pkt;
  logic [1:0] pipe_val;
  logic [1:0] pipe_rdy;
  issue_pkt_t pipe_pkt;
  complete_t  complete;
  logic       wb_cyc;
  logic       wb_stb;
  logic       wb_we;
  logic [1:0] wb_adr;
  word_t      wb_dat_w;
  word_t      wb_dat_r;
  logic       wb_ack;

  // Model state
  word_t       m_regs [32];
  logic [31:0] m_pend = '0;
  logic        m_entry_val = 1'b0;
  fetch_pkt_t  m_entry = '0;
  logic        m_en = 1'b0;
  logic        m_ack = 1'b0;
  word_t       m_issued = '0;
  word_t       m_stalls = '0;
  word_t       m_illegal = '0;
  complete_t   alu_q [$];
  complete_t   mul_q [$];

  logic [31:0] rng = 32'h7b0a;
  logic        traffic_on = 1'b0;
  logic        fetch_taken = 1'b0;
  seq_t        next_seq = '0;
  word_t       next_pc = '0;
  int          pv_count = 0;
  int          n_xfers = 0;
  int          n_errors = 0;
  int          n_timeouts = 0;

  decode_issue_top decode_issue_top_i (
    .clk       (clk),
    .rst       (rst),
    .fetch_val (fetch_val),
    .fetch_rdy (fetch_rdy),
    .fetch_pkt (fetch_pkt),
    .pipe_val  (pipe_val),
    .pipe_rdy  (pipe_rdy),
    .pipe_pkt  (pipe_pkt),
    .complete  (complete),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_dat_r  (wb_dat_r),
    .wb_ack    (wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // --------------------
  // Helpers
  // --------------------

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function logic [31:0] rand32();
    rng = xorshift(rng);
    return rng;
  endfunction

  // Registers from x0 to x7 keep hazards dense
  function word_t random_inst();
    logic [31:0] r;
    logic [31:0] s;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    r   = rand32();
    s   = rand32();
    rd  = {2'b00, r[2:0]};
    rs1 = {2'b00, r[5:3]};
    rs2 = {2'b00, r[8:6]};
    // About 1 in 16 words are junk
    if (r[12:9] == 4'd0) begin
      if (r[13]) begin
        return s;
      end
      return {s[31:25], rs2, rs1, s[14:12], rd, 7'b0110011};
    end
    case (4'(r[17:14] % 4'd12))
      4'd0:    return {7'h00, rs2, rs1, 3'b000, rd, 7'b0110011};
      4'd1:    return {7'h20, rs2, rs1, 3'b000, rd, 7'b0110011};
      4'd2:    return {7'h00, rs2, rs1, 3'b111, rd, 7'b0110011};
      4'd3:    return {7'h00, rs2, rs1, 3'b110, rd, 7'b0110011};
      4'd4:    return {7'h00, rs2, rs1, 3'b100, rd, 7'b0110011};
      4'd5:    return {7'h00, rs2, rs1, 3'b010, rd, 7'b0110011};
      4'd6:    return {7'h01, rs2, rs1, 3'b000, rd, 7'b0110011};
      4'd7:    return {s[11:0], rs1, 3'b000, rd, 7'b0010011};
      4'd8:    return {s[11:0], rs1, 3'b111, rd, 7'b0010011};
      4'd9:    return {s[11:0], rs1, 3'b110, rd, 7'b0010011};
      4'd10:   return {s[11:0], rs1, 3'b100, rd, 7'b0010011};
      default: return {s[31:12], rd, 7'b0110111};
    endcase
  endfunction

  // RV32 subset, written from the encoding tables
  function ref_dec_t decode_ref(input word_t w);
    ref_dec_t d;
    d         = '0;
    d.rs1     = w[19:15];
    d.rs2     = w[24:20];
    d.rd      = w[11:7];
    d.legal   = 1'b1;
    d.use_rs1 = 1'b1;
    casez (w)
      32'b0000000_?????_?????_000_?????_0110011: d.uop = UOP_ADD;
      32'b0100000_?????_?????_000_?????_0110011: d.uop = UOP_SUB;
      32'b0000000_?????_?????_111_?????_0110011: d.uop = UOP_AND;
      32'b0000000_?????_?????_110_?????_0110011: d.uop = UOP_OR;
      32'b0000000_?????_?????_100_?????_0110011: d.uop = UOP_XOR;
      32'b0000000_?????_?????_010_?????_0110011: d.uop = UOP_SLT;
      32'b0000001_?????_?????_000_?????_0110011: d.uop = UOP_MUL;
      32'b???????_?????_?????_000_?????_0010011: d.uop = UOP_ADD;
      32'b???????_?????_?????_111_?????_0010011: d.uop = UOP_AND;
      32'b???????_?????_?????_110_?????_0010011: d.uop = UOP_OR;
      32'b???????_?????_?????_100_?????_0010011: d.uop = UOP_XOR;
      32'b????????????????????_?????_0110111:    d.uop = UOP_LUI;
      default:                                   d.legal = 1'b0;
    endcase
    d.use_rs2 = d.legal && (w[6:0] == 7'b0110011);
    d.use_imm = d.legal && !d.use_rs2;
    if (w[6:0] == 7'b0110111) begin
      // lui reads no source
      d.use_rs1 = 1'b0;
      d.imm     = {w[31:12], 12'b0};
    end else if (d.use_imm) begin
      d.imm = {{20{w[31]}}, w[31:20]};
    end
    return d;
  endfunction

  task report_mismatch(input string what, input word_t got, input word_t exp);
    n_errors++;
    $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
  endtask

  // One Wishbone classic access, waits for its ack
  task bus_access(input logic we, input logic [1:0] adr, input word_t wdata,
                  output word_t rdata);
    int   waited;
    logic got;
    waited = 0;
    got    = 1'b0;
    rdata  = '0;
    @(posedge clk);
    #2;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdata;
    while (!got && waited < WB_TIMEOUT) begin
      @(negedge clk);
      waited++;
      if (wb_ack) begin
        got   = 1'b1;
        rdata = wb_dat_r;
      end
    end
    if (!got) begin
      n_timeouts++;
      $display("Timeout at %0t: no ack for register %0d", $time, adr);
    end
    @(posedge clk);
    #2;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  // --------------------
  // Stimulus
  // --------------------

  always @(posedge clk) begin : stimulus
    logic [31:0] r;
    complete_t   c;
    #2;
    r        = rand32();
    pipe_rdy = {r[3:2] != 2'b00, r[1:0] != 2'b00};
    c        = '0;
    // Oldest instruction of a random pipe completes
    if (r[6:4] < 3'd4) begin
      if (r[7] && mul_q.size() != 0) begin
        c = mul_q.pop_front();
      end else if (!r[7] && alu_q.size() != 0) begin
        c = alu_q.pop_front();
      end
      c.wdata = rand32();
    end
    complete = c;
    // Held offer stays until taken
    if (!(fetch_val && !fetch_taken)) begin
      if (traffic_on && r[9:8] != 2'b00) begin
        fetch_val      = 1'b1;
        fetch_pkt.inst = random_inst();
        fetch_pkt.pc   = next_pc;
        fetch_pkt.seq  = next_seq;
        next_pc        = next_pc + 32'd4;
        next_seq       = next_seq + 8'd1;
      end else begin
        fetch_val = 1'b0;
      end
    end
  end

  // --------------------
  // Monitor and model
  // --------------------

  always @(negedge clk) begin : monitor
    ref_dec_t   d;
    logic       hazard;
    logic       issue;
    logic       drop;
    logic       exp_frdy;
    logic       req;
    logic [1:0] exp_pv;
    complete_t  c;
    if (!rst) begin
      d      = decode_ref(m_entry.inst);
      hazard = (d.use_rs1 && m_pend[d.rs1]) || (d.use_rs2 && m_pend[d.rs2]) ||
               (d.legal && m_pend[d.rd]);
      exp_pv = 2'b00;
      if (m_entry_val && d.legal && m_en && !hazard) begin
        exp_pv = (d.uop == UOP_MUL) ? 2'b10 : 2'b01;
      end
      issue    = |(exp_pv & pipe_rdy);
      drop     = m_entry_val && !d.legal;
      exp_frdy = !m_entry_val || issue || drop;
      assert (pipe_val == exp_pv)
        else report_mismatch("pipe_val", 32'(pipe_val), 32'(exp_pv));
      assert (fetch_rdy == exp_frdy)
        else report_mismatch("fetch_rdy", 32'(fetch_rdy), 32'(exp_frdy));
      if (pipe_val != 2'b00) begin
        pv_count++;
      end
      // Transfers as the DUT shows them
      if (|(pipe_val & pipe_rdy)) begin
        n_xfers++;
      end
      if (issue) begin
        assert (pipe_pkt.pc == m_entry.pc)
          else report_mismatch("pc", pipe_pkt.pc, m_entry.pc);
        assert (pipe_pkt.seq == m_entry.seq)
          else report_mismatch("seq", 32'(pipe_pkt.seq), 32'(m_entry.seq));
        assert (pipe_pkt.uop == d.uop)
          else report_mismatch("uop", 32'(pipe_pkt.uop), 32'(d.uop));
        assert (pipe_pkt.rd == d.rd && pipe_pkt.rd_wen)
          else report_mismatch("rd", 32'(pipe_pkt.rd), 32'(d.rd));
        // x0 entry of the model stays zero
        assert (pipe_pkt.op1 == (d.use_rs1 ? m_regs[d.rs1] : '0))
          else report_mismatch("op1", pipe_pkt.op1, d.use_rs1 ? m_regs[d.rs1] : '0);
        assert (pipe_pkt.op2 == (d.use_imm ? d.imm : m_regs[d.rs2]))
          else report_mismatch("op2", pipe_pkt.op2, d.use_imm ? d.imm : m_regs[d.rs2]);
        c        = '0;
        c.val    = 1'b1;
        c.rd     = d.rd;
        c.rd_wen = 1'b1;
        if (exp_pv[1]) begin
          mul_q.push_back(c);
        end else begin
          alu_q.push_back(c);
        end
        m_issued = m_issued + 32'd1;
      end
      if (m_entry_val && d.legal && m_en && hazard) begin
        m_stalls = m_stalls + 32'd1;
      end
      if (drop) begin
        m_illegal = m_illegal + 32'd1;
      end
      // Writeback lands at the edge
      if (complete.val && complete.rd_wen && complete.rd != '0) begin
        m_regs[complete.rd] = complete.wdata;
        m_pend[complete.rd] = 1'b0;
      end
      if (issue && d.rd != '0) begin
        m_pend[d.rd] = 1'b1;
      end
      fetch_taken = fetch_val && exp_frdy;
      if (fetch_taken) begin
        m_entry     = fetch_pkt;
        m_entry_val = 1'b1;
      end else if (issue || drop) begin
        m_entry_val = 1'b0;
      end
      // Classic slave, single-cycle ack
      req = wb_cyc && wb_stb && !m_ack;
      assert (wb_ack == m_ack)
        else report_mismatch("wb_ack", 32'(wb_ack), 32'(m_ack));
      m_ack = req;
      if (req && wb_we) begin
        case (wb_adr)
          2'd0:    m_en = wb_dat_w[0];
          2'd1:    m_issued = '0;
          2'd2:    m_stalls = '0;
          default: m_illegal = '0;
        endcase
      end
    end
  end

  // --------------------
  // Test sequence
  // --------------------

  initial begin
    word_t rdata;
    int    start;
    int    waited;
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end
    rst       = 1'b1;
    fetch_val = 1'b0;
    fetch_pkt = '0;
    pipe_rdy  = '0;
    complete  = '0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_w  = '0;
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;

    // Enable issue, then hazard-dense traffic
    bus_access(1'b1, 2'd0, 32'd1, rdata);
    traffic_on = 1'b1;
    repeat (1500) @(posedge clk);

    // With issue disabled nothing may reach a pipe
    bus_access(1'b1, 2'd0, 32'd0, rdata);
    pv_count = 0;
    repeat (100) @(posedge clk);
    assert (pv_count == 0)
      else report_mismatch("pipe_val count while disabled", 32'(pv_count), '0);
    bus_access(1'b1, 2'd0, 32'd1, rdata);
    start  = n_xfers;
    waited = 0;
    while (n_xfers == start && waited < RESUME_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (n_xfers == start) begin
      n_timeouts++;
      $display("Timeout at %0t: issue did not resume after enable", $time);
    end
    repeat (500) @(posedge clk);

    // Drain fetch, issue register and both pipes
    traffic_on = 1'b0;
    waited     = 0;
    while ((fetch_val || m_entry_val || alu_q.size() != 0 || mul_q.size() != 0) &&
           waited < DRAIN_TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (waited >= DRAIN_TIMEOUT) begin
      n_timeouts++;
      $display("Timeout at %0t: stage did not drain", $time);
    end

    // Counters against the model
    bus_access(1'b0, 2'd1, '0, rdata);
    assert (rdata == m_issued) else report_mismatch("ISSUED", rdata, m_issued);
    bus_access(1'b0, 2'd2, '0, rdata);
    assert (rdata == m_stalls) else report_mismatch("STALLS", rdata, m_stalls);
    assert (rdata != '0) else report_mismatch("STALLS after hazards", rdata, 32'd1);
    bus_access(1'b0, 2'd3, '0, rdata);
    assert (rdata == m_illegal) else report_mismatch("ILLEGAL", rdata, m_illegal);
    bus_access(1'b0, 2'd0, '0, rdata);
    assert (rdata == 32'd1) else report_mismatch("CTRL", rdata, 32'd1);
    // Write clears the addressed counter
    for (int a = 1; a < 4; a++) begin
      bus_access(1'b1, 2'(a), '1, rdata);
      bus_access(1'b0, 2'(a), '0, rdata);
      assert (rdata == '0) else report_mismatch("counter after clear", rdata, '0);
    end
    repeat (2) @(posedge clk);

    $display("Value errors: %0d, timeouts: %0d, transfers checked: %0d",
             n_errors, n_timeouts, n_xfers);
    if (n_errors == 0 && n_timeouts == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
decode_pkg.sv
inst_decoder.sv
regfile_pending.sv
issue_unit.sv
issue_csr.sv
decode_issue_top.sv
tb_decode_issue.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_decode_issue
FILELIST = sources.f

SOURCES  = $(shell grep -v '^+' $(FILELIST)) decode_config.svh
BIN      = obj_dir/V$(TOP)
LOG      = sim.log

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi; exit $$rc

clean:
	rm -rf obj_dir $(LOG)
